//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire pipe_pkg::stage_rec_t in_rec,
    input  wire                     advance,
    input  wire pipe_pkg::stage_rec_t ex_rec,
    output logic                    hold,
    input  wire                     wb_en,
    input  wire pipe_pkg::reg_idx_t wb_rd,
    input  wire pipe_pkg::word_t    wb_data,
    output pipe_pkg::stage_rec_t    out_rec
);
    import pipe_pkg::*;

    word_t      regs [8];
    stall_cnt_t stall_acc;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       load_use;

    // Writeback in the same cycle is seen by the read
    function automatic word_t read_reg(input reg_idx_t idx);
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        uses_rs1 = in_rec.op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LD, OP_ST};
        uses_rs2 = in_rec.op inside {OP_ADD, OP_SUB, OP_ST};
    end

    // LD in execute has no data yet for a dependent in decode
    assign load_use = ex_rec.valid && ex_rec.op == OP_LD &&
                      ((uses_rs1 && ex_rec.rd == in_rec.rs1) ||
                       (uses_rs2 && ex_rec.rd == in_rec.rs2));

    assign hold = in_rec.valid && load_use;

    // Register file
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_rec   <= '0;
            stall_acc <= '0;
        end else if (advance) begin
            if (hold) begin
                // Bubble into execute, count the lost cycle
                out_rec.valid <= 1'b0;
                if (stall_acc != '1) begin
                    stall_acc <= stall_acc + 1'b1;
                end
            end else begin
                out_rec           <= in_rec;
                out_rec.opa       <= read_reg(in_rec.rs1);
                out_rec.opb       <= read_reg(in_rec.rs2);
                out_rec.stall_cnt <= stall_acc;
                stall_acc         <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire pipe_pkg::stage_rec_t in_rec,
    input  wire                       advance,
    input  wire pipe_pkg::stage_rec_t mem_rec,
    input  wire pipe_pkg::stage_rec_t wb_rec,
    output pipe_pkg::stage_rec_t      out_rec
);
    import pipe_pkg::*;

    word_t opa;
    word_t opb;
    word_t imm_ext;
    word_t result;

    // Nearer producer wins; a load in memory has only its address so far
    function automatic word_t fwd(input reg_idx_t idx, input word_t reg_val);
        if (mem_rec.valid && mem_rec.we && mem_rec.op != OP_LD && mem_rec.rd == idx) begin
            return mem_rec.result;
        end
        if (wb_rec.valid && wb_rec.we && wb_rec.rd == idx) begin
            return wb_rec.result;
        end
        return reg_val;
    endfunction

    always_comb begin
        opa     = fwd(in_rec.rs1, in_rec.opa);
        opb     = fwd(in_rec.rs2, in_rec.opb);
        imm_ext = {{10{in_rec.imm[5]}}, in_rec.imm};
        case (in_rec.op)
            OP_ADD:        result = opa + opb;
            OP_SUB:        result = opa - opb;
            OP_ADDI:       result = opa + imm_ext;
            OP_LD, OP_ST:  result = opa + imm_ext;    // effective address
            default:       result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_rec <= '0;
        end else if (advance) begin
            out_rec        <= in_rec;
            out_rec.opa    <= opa;
            // Store data travels on in opb
            out_rec.opb    <= opb;
            out_rec.result <= result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   instr_req,
    output logic                  instr_ack,
    input  wire pipe_pkg::instr_t instr_word,
    input  wire                   advance,
    input  wire                   hold,
    output pipe_pkg::stage_rec_t  out_rec
);
    import pipe_pkg::*;

    fetch_state_t state;
    seq_t         next_seq;
    logic         take;
    stage_rec_t   word_rec;

    // Slot is usable when empty or when its record moves into decode now
    assign take = (state == F_IDLE) && instr_req && (!out_rec.valid || (advance && !hold));

    always_comb begin
        word_rec           = '0;
        word_rec.valid     = 1'b1;
        word_rec.seq       = next_seq;
        word_rec.op        = instr_word.op;
        word_rec.rd        = instr_word.rd;
        word_rec.rs1       = instr_word.rs1;
        word_rec.imm       = instr_word.imm;
        // A store reads its data register through the second source
        word_rec.rs2       = (instr_word.op == OP_ST) ? instr_word.rd : instr_word.imm[2:0];
        word_rec.we        = instr_word.op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LD};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= F_IDLE;
            instr_ack <= 1'b0;
            next_seq  <= '0;
            out_rec   <= '0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (take) begin
                        state     <= F_ACK;
                        instr_ack <= 1'b1;
                    end
                end
                F_ACK: begin
                    // Wait for the driver to release the request
                    if (!instr_req) begin
                        state     <= F_IDLE;
                        instr_ack <= 1'b0;
                    end
                end
                default: state <= F_IDLE;
            endcase

            if (take) begin
                out_rec  <= word_rec;
                next_seq <= next_seq + 1'b1;
            end else if (advance && !hold) begin
                out_rec.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 16
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire pipe_pkg::stage_rec_t in_rec,
    input  wire                       advance,
    output pipe_pkg::stage_rec_t      out_rec
);
    import pipe_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    word_t         dmem [DMEM_WORDS];
    logic [AW-1:0] addr;

    // Address wraps around the memory size
    assign addr = AW'(in_rec.result % DMEM_WORDS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
            out_rec <= '0;
        end else if (advance) begin
            if (in_rec.valid && in_rec.op == OP_ST) begin
                dmem[addr] <= in_rec.opb;
            end
            out_rec <= in_rec;
            // Loaded word replaces the address
            if (in_rec.op == OP_LD) begin
                out_rec.result <= dmem[addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef logic [2:0]  reg_idx_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  seq_t;
    typedef logic [3:0]  stall_cnt_t;
    typedef logic [15:0] stamp_t;
    typedef logic [5:0]  imm_t;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_ADDI = 3'd3,
        OP_LD   = 3'd4,
        OP_ST   = 3'd5
    } opcode_t;

    // rs2 sits in imm[2:0] for register-register operations
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        logic     rsvd;
        imm_t     imm;
    } instr_t;

    // Record carried between pipeline stages
    typedef struct packed {
        logic       valid;
        seq_t       seq;
        opcode_t    op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      opa;
        word_t      opb;
        imm_t       imm;
        word_t      result;
        logic       we;
        stall_cnt_t stall_cnt;
    } stage_rec_t;

    // Completion record offered on the retire port
    typedef struct packed {
        seq_t       seq;
        reg_idx_t   rd;
        logic       we;
        word_t      result;
        stall_cnt_t stall_cnt;
        stamp_t     stamp;
    } retire_rec_t;

    typedef enum logic {
        F_IDLE,
        F_ACK
    } fetch_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_DROP
    } retire_state_t;

endpackage

`default_nettype wire

//--- hdl/pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top #(
    parameter int DMEM_WORDS = 16
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    instr_req,
    output logic                   instr_ack,
    input  wire pipe_pkg::instr_t  instr_word,
    output logic                   retire_req,
    input  wire                    retire_ack,
    output pipe_pkg::retire_rec_t  retire_rec
);
    import pipe_pkg::*;

    // Stage registers, named by the boundary they sit on
    stage_rec_t if_id;
    stage_rec_t id_ex;
    stage_rec_t ex_mem;
    stage_rec_t mem_wb;
    stage_rec_t wb_fwd;

    logic       advance;
    logic       hold;
    logic       wb_en;
    reg_idx_t   wb_rd;
    word_t      wb_data;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .instr_req  (instr_req),
        .instr_ack  (instr_ack),
        .instr_word (instr_word),
        .advance    (advance),
        .hold       (hold),
        .out_rec    (if_id)
    );

    // Decode checks its own output register for a load in execute
    decode_stage u_decode (
        .clk     (clk),
        .rst     (rst),
        .in_rec  (if_id),
        .advance (advance),
        .ex_rec  (id_ex),
        .hold    (hold),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .out_rec (id_ex)
    );

    execute_stage u_execute (
        .clk     (clk),
        .rst     (rst),
        .in_rec  (id_ex),
        .advance (advance),
        .mem_rec (ex_mem),
        .wb_rec  (wb_fwd),
        .out_rec (ex_mem)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .clk     (clk),
        .rst     (rst),
        .in_rec  (ex_mem),
        .advance (advance),
        .out_rec (mem_wb)
    );

    pipe_tracker u_tracker (
        .clk        (clk),
        .rst        (rst),
        .in_rec     (mem_wb),
        .advance    (advance),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_rec     (wb_fwd),
        .retire_req (retire_req),
        .retire_ack (retire_ack),
        .retire_rec (retire_rec)
    );

endmodule

`default_nettype wire

//--- hdl/pipe_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_tracker (
    input  wire                       clk,
    input  wire                       rst,
    input  wire pipe_pkg::stage_rec_t in_rec,
    output logic                      advance,
    output logic                      wb_en,
    output pipe_pkg::reg_idx_t        wb_rd,
    output pipe_pkg::word_t           wb_data,
    output pipe_pkg::stage_rec_t      wb_rec,
    output logic                      retire_req,
    input  wire                       retire_ack,
    output pipe_pkg::retire_rec_t     retire_rec
);
    import pipe_pkg::*;

    retire_state_t state;
    stamp_t        cycle;
    logic          capture;

    // Slot takes a record only when the previous one has fully retired
    assign capture = in_rec.valid && (state == R_IDLE);
    assign advance = !in_rec.valid || (state == R_IDLE);

    // Register write happens as the record enters the slot
    assign wb_en   = capture && in_rec.we;
    assign wb_rd   = in_rec.rd;
    assign wb_data = in_rec.result;

    // Writeback record used by execute for forwarding
    assign wb_rec  = in_rec;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // Four-phase output handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= R_IDLE;
            retire_req <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (capture) begin
                        state      <= R_REQ;
                        retire_req <= 1'b1;
                    end
                end
                R_REQ: begin
                    if (retire_ack) begin
                        state      <= R_DROP;
                        retire_req <= 1'b0;
                    end
                end
                R_DROP: begin
                    if (!retire_ack) state <= R_IDLE;
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            retire_rec <= '{seq: in_rec.seq, rd: in_rec.rd, we: in_rec.we,
                            result: in_rec.result, stall_cnt: in_rec.stall_cnt,
                            stamp: cycle};
        end
    end

endmodule

`default_nettype wire

//--- pipe_top.f
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/pipe_tracker.sv
hdl/pipe_top.sv
+incdir+tests
tests/pipe_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pipe_tb \
    -f pipe_top.f -o pipe_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/pipe_sim > sim.log 2>&1 || echo "Simulator returned a failing status"
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
    || { echo "No result found in sim.log"; exit 1; }

//--- tests/pipe_model.svh
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

localparam int TABLE_LEN = 20;
localparam int RAND_LEN  = 60;
localparam int N_TOTAL   = TABLE_LEN + RAND_LEN;

// Architectural state of the model
word_t      model_regs [8];
word_t      model_dmem [DMEM_WORDS];
logic       prev_was_ld;
reg_idx_t   prev_ld_rd;

// Expected completion fields, indexed by sequence number
reg_idx_t   exp_rd     [N_TOTAL];
logic       exp_we     [N_TOTAL];
word_t      exp_result [N_TOTAL];
stall_cnt_t exp_stall  [N_TOTAL];

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic instr_t make_instr(input opcode_t op, input reg_idx_t rd,
                                      input reg_idx_t rs1, input imm_t imm);
    instr_t w;
    w.op   = op;
    w.rd   = rd;
    w.rs1  = rs1;
    w.rsvd = 1'b0;
    w.imm  = imm;
    return w;
endfunction

// Setup first, load-use pairs once the pipeline is full
function automatic instr_t table_instr(input int idx);
    case (idx)
        0:  return make_instr(OP_ADDI, 3'd1, 3'd0, 6'd5);
        1:  return make_instr(OP_ADDI, 3'd2, 3'd0, 6'h3d);
        2:  return make_instr(OP_ADD,  3'd3, 3'd1, 6'd2);
        3:  return make_instr(OP_SUB,  3'd4, 3'd3, 6'd1);
        4:  return make_instr(OP_ST,   3'd4, 3'd1, 6'd2);
        5:  return make_instr(OP_ST,   3'd1, 3'd0, 6'd3);
        6:  return make_instr(OP_ADDI, 3'd5, 3'd5, 6'd1);
        7:  return make_instr(OP_NOP,  3'd0, 3'd0, 6'd0);
        8:  return make_instr(OP_LD,   3'd6, 3'd1, 6'd2);
        9:  return make_instr(OP_ADD,  3'd7, 3'd6, 6'd1);
        10: return make_instr(OP_LD,   3'd2, 3'd0, 6'd3);
        11: return make_instr(OP_SUB,  3'd3, 3'd1, 6'd2);
        12: return make_instr(OP_LD,   3'd5, 3'd0, 6'd7);
        13: return make_instr(OP_ST,   3'd5, 3'd0, 6'd9);
        14: return make_instr(OP_LD,   3'd1, 3'd0, 6'd9);
        15: return make_instr(OP_ADDI, 3'd1, 3'd1, 6'd1);
        16: return make_instr(OP_LD,   3'd7, 3'd2, 6'd0);
        17: return make_instr(OP_ADD,  3'd0, 3'd3, 6'd4);
        18: return make_instr(OP_ADD,  3'd6, 3'd6, 6'd7);
        default: return make_instr(OP_SUB, 3'd2, 3'd6, 6'd0);
    endcase
endfunction

// A source that is the rd of the LD sent just before
function automatic logic is_load_use(input instr_t w);
    reg_idx_t src2;
    logic     use1;
    logic     use2;
    src2 = (w.op == OP_ST) ? w.rd : w.imm[2:0];
    use1 = w.op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LD, OP_ST};
    use2 = w.op inside {OP_ADD, OP_SUB, OP_ST};
    return prev_was_ld && ((use1 && w.rs1 == prev_ld_rd) || (use2 && src2 == prev_ld_rd));
endfunction

function automatic instr_t avoid_load_use(input instr_t w);
    if (is_load_use(w)) begin
        return make_instr(OP_ADDI, w.rd, prev_ld_rd + 3'd1, w.imm);
    end
    return w;
endfunction

task automatic model_reset();
    for (int i = 0; i < 8; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        model_dmem[i] = '0;
    end
    prev_was_ld = 1'b0;
    prev_ld_rd  = '0;
endtask

task automatic model_exec(input instr_t w, input int seq);
    word_t a;
    word_t b;
    word_t addr;
    word_t res;
    logic  we;
    a    = model_regs[w.rs1];
    b    = model_regs[w.imm[2:0]];
    addr = a + {{10{w.imm[5]}}, w.imm};
    res  = '0;
    we   = 1'b1;
    case (w.op)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_ADDI: res = addr;
        OP_LD:   res = model_dmem[int'(addr) % DMEM_WORDS];
        OP_ST: begin
            model_dmem[int'(addr) % DMEM_WORDS] = model_regs[w.rd];
            res = addr;
            we  = 1'b0;
        end
        default: we = 1'b0;
    endcase
    exp_rd[seq]     = w.rd;
    exp_we[seq]     = we;
    exp_result[seq] = res;
    exp_stall[seq]  = is_load_use(w) ? 4'd1 : 4'd0;
    if (we) begin
        model_regs[w.rd] = res;
    end
    prev_was_ld = (w.op == OP_LD);
    prev_ld_rd  = w.rd;
endtask

`endif

//--- tests/pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;
    import pipe_pkg::*;

    localparam int DMEM_WORDS = 16;

    `include "pipe_model.svh"

    localparam int CYCLE_LIMIT = 40 * N_TOTAL + 100;
    // Slow retire while the table runs, so the pipeline fills up
    localparam int TABLE_HOLD  = 10;
    // Long enough for one more record to be offered after the last handshake
    localparam int DRAIN_CYCLES = 20;

    logic        clk;
    logic        rst;
    logic        instr_req;
    logic        instr_ack;
    instr_t      instr_word;
    logic        retire_req;
    logic        retire_ack;
    retire_rec_t retire_rec;

    int          cycle_cnt = 0;
    int          retired = 0;
    logic        prev_instr_req;
    logic        prev_instr_ack;
    logic        prev_retire_req;
    logic        prev_retire_ack;
    retire_rec_t prev_rec;

    pipe_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .instr_req  (instr_req),
        .instr_ack  (instr_ack),
        .instr_word (instr_word),
        .retire_req (retire_req),
        .retire_ack (retire_ack),
        .retire_rec (retire_rec)
    );

    task automatic stop_on_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_record(input int exp_seq, input stamp_t last_stamp, input int count);
        assert (exp_seq < N_TOTAL) else begin
            $display("Retire port offered more records than instructions were sent");
            stop_on_failure();
        end
        check_value("retire_rec.seq", 16'(retire_rec.seq), 16'(exp_seq[7:0]));
        check_value("retire_rec.rd", 16'(retire_rec.rd), 16'(exp_rd[exp_seq]));
        check_value("retire_rec.we", 16'(retire_rec.we), 16'(exp_we[exp_seq]));
        check_value("retire_rec.result", retire_rec.result, exp_result[exp_seq]);
        check_value("retire_rec.stall_cnt", 16'(retire_rec.stall_cnt),
                    16'(exp_stall[exp_seq]));
        assert (count == 0 || retire_rec.stamp > last_stamp) else begin
            $display("** Error: retire_rec.stamp = 0x%h, previous 0x%h",
                     retire_rec.stamp, last_stamp);
            stop_on_failure();
        end
    endtask

    task automatic send_instr(input instr_t w);
        instr_word <= w;
        instr_req  <= 1'b1;
        do @(posedge clk); while (!instr_ack);
        instr_req <= 1'b0;
        do @(posedge clk); while (instr_ack);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction driver and model
    initial begin
        instr_t      w;
        logic [31:0] seed;
        rst        = 1'b1;
        instr_req  = 1'b0;
        instr_word = '0;
        model_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!instr_ack && !retire_req) else begin
            $display("** Error: instr_ack = 0x%h, retire_req = 0x%h after reset, expected 0x0",
                     instr_ack, retire_req);
            stop_on_failure();
        end
        seed = 32'd47;
        for (int i = 0; i < N_TOTAL; i++) begin
            if (i < TABLE_LEN) begin
                w = table_instr(i);
            end else begin
                seed = lcg_next(seed);
                w = make_instr(opcode_t'(3'(seed[31:16] % 16'd6)), seed[24:22],
                               seed[21:19], seed[18:13]);
                w = avoid_load_use(w);
            end
            model_exec(w, i);
            send_instr(w);
        end
        while (retired < N_TOTAL) @(posedge clk);
        // An extra record in this window fails in the retire responder
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Retire responder with random back-pressure
    initial begin
        logic [31:0] rseed;
        int          delay;
        stamp_t      last_stamp;
        retire_ack = 1'b0;
        rseed      = 32'd47;
        last_stamp = '0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            if (retire_req) begin
                check_record(retired, last_stamp, retired);
                last_stamp = retire_rec.stamp;
                retired    = retired + 1;
                rseed      = lcg_next(rseed);
                delay      = int'(rseed[31:16] % 16'd6);
                if (retired <= TABLE_LEN) begin
                    delay = delay + TABLE_HOLD;
                end
                repeat (delay) @(posedge clk);
                retire_ack <= 1'b1;
                do @(posedge clk); while (retire_req);
                retire_ack <= 1'b0;
            end
        end
    end

    // Handshake rules on both ports
    always @(posedge clk) begin
        if (!rst) begin
            if (retire_req && prev_retire_req) begin
                assert (retire_rec == prev_rec) else begin
                    $display("** Error: retire_rec = 0x%h changed from 0x%h under retire_req",
                             retire_rec, prev_rec);
                    stop_on_failure();
                end
            end
            if (retire_req && !prev_retire_req) begin
                assert (!prev_retire_ack) else begin
                    $display("** Error: retire_req rose while retire_ack = 0x%h",
                             prev_retire_ack);
                    stop_on_failure();
                end
            end
            if (instr_ack && !prev_instr_ack) begin
                assert (prev_instr_req) else begin
                    $display("** Error: instr_ack rose while instr_req = 0x%h",
                             prev_instr_req);
                    stop_on_failure();
                end
            end
        end
        prev_instr_req  <= instr_req;
        prev_instr_ack  <= instr_ack;
        prev_retire_req <= retire_req;
        prev_retire_ack <= retire_ack;
        prev_rec        <= retire_rec;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: only %0d of %0d instructions retired after %0d cycles",
                     retired, N_TOTAL, cycle_cnt);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire
